// ==== Makefile ====
# Verilator build and run of the AES-256 core testbench
VERILATOR ?= verilator
TOP       ?= tb_aes256_enc
FILELIST  ?= aes256_enc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

.PHONY: sim clean

# Pass only if the exact pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== aes256_enc.f ====
aes_pkg.sv
aes_key_rom.sv
aes_sbox_stream.sv
aes_shift_buffer.sv
aes_mix_add.sv
aes_ctrl.sv
aes256_enc.sv
tb_aes256_enc.sv

// ==== aes256_enc.sv ====
//************************************************
// AES-256 encryption core, fixed key. Strobe ctrl_data_in with a block,
// the ciphertext follows with a one-cycle ctrl_data_out.
//************************************************
`timescale 1ns/1ps

module aes256_enc
    import aes_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic [127:0] inp_aes,       // Byte k in bits 8k+7:8k
    input  logic         ctrl_data_in,  // Start strobe
    output logic [127:0] out_aes,       // Held until the next result
    output logic         ctrl_data_out  // Done strobe
);

    aes_block_u in_block;
    aes_block_u round_key;
    aes_block_u state;
    aes_block_u shifted;
    logic [7:0] sub_byte;
    logic       sub_valid;
    logic       load_state, add_key, sub_start, skip_mix, done, busy;
    logic [3:0] byte_idx;
    logic [3:0] round;

    // Capture only when the core accepts the strobe
    always_ff @(posedge clk)
    begin
        if (ctrl_data_in && !busy)
            in_block <= inp_aes;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ctrl_data_out <= 1'b0;
            out_aes       <= '0;
        end
        else
        begin
            ctrl_data_out <= done;
            if (done)
                out_aes <= state;       // Final key already added
        end
    end

    aes_ctrl aes_ctrl_inst (
        .clk(clk), .resetn(resetn), .start(ctrl_data_in),
        .load_state(load_state), .add_key(add_key), .sub_start(sub_start),
        .byte_idx(byte_idx), .round(round), .skip_mix(skip_mix),
        .done(done), .busy(busy)
    );

    aes_key_rom aes_key_rom_inst (
        .clk(clk), .resetn(resetn), .round(round), .round_key(round_key)
    );

    aes_sbox_stream aes_sbox_stream_inst (
        .clk(clk), .resetn(resetn), .sub_start(sub_start), .state(state),
        .sub_byte(sub_byte), .sub_valid(sub_valid)
    );

    aes_shift_buffer aes_shift_buffer_inst (
        .clk(clk), .resetn(resetn), .sub_valid(sub_valid), .byte_idx(byte_idx),
        .sub_byte(sub_byte), .shifted(shifted)
    );

    aes_mix_add aes_mix_add_inst (
        .clk(clk), .resetn(resetn), .load_state(load_state), .add_key(add_key),
        .skip_mix(skip_mix), .round(round), .inp_block(in_block),
        .shifted(shifted), .round_key(round_key), .state(state)
    );

    // Single-cycle done, FSM already back in idle
    assert property (@(posedge clk) disable iff (!resetn)
        ctrl_data_out |-> !$past(ctrl_data_out) && aes_ctrl_inst.ctrl_st == st_idle);

endmodule

// ==== aes_ctrl.sv ====
//************************************************
// Round sequencer. Counts rounds and bytes and drives the datapath strobes.
//************************************************
`timescale 1ns/1ps

module aes_ctrl
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,       // Ignored unless idle
    output logic       load_state,
    output logic       add_key,
    output logic       sub_start,
    output logic [3:0] byte_idx,
    output logic [3:0] round,
    output logic       skip_mix,
    output logic       done,
    output logic       busy
);

    aes_ctrl_st_e ctrl_st, ctrl_st_next;
    logic [3:0]   byte_cnt;
    logic [3:0]   round_cnt;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            ctrl_st <= st_idle;
        else
            ctrl_st <= ctrl_st_next;
    end

    always_comb
    begin
        ctrl_st_next = ctrl_st;
        case (ctrl_st)
            st_idle:      if (start) ctrl_st_next = st_add_key;
            st_add_key:   ctrl_st_next = skip_mix ? st_done : st_sub_bytes;
            st_sub_bytes: if (byte_cnt == 4'(AES_BYTES - 1)) ctrl_st_next = st_drain;
            st_drain:     ctrl_st_next = skip_mix ? st_add_key : st_mix;
            st_mix:       ctrl_st_next = st_add_key;
            st_done:      ctrl_st_next = st_idle;
            default:      ctrl_st_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            byte_cnt  <= 4'd0;
            round_cnt <= 4'd0;
        end
        else
        begin
            if (ctrl_st == st_sub_bytes)
                byte_cnt <= byte_cnt + 4'd1;   // Wraps to 0 after byte 15
            else
                byte_cnt <= 4'd0;
            // Cleared early so key 0 is ready for a start in the first idle cycle
            if (ctrl_st == st_idle || ctrl_st == st_done)
                round_cnt <= 4'd0;
            else if (ctrl_st == st_sub_bytes && byte_cnt == 4'(AES_BYTES - 1))
                round_cnt <= round_cnt + 4'd1; // Ahead of add_key for the ROM
        end
    end

    assign skip_mix   = (round_cnt == 4'(AES_ROUNDS));
    assign add_key    = (ctrl_st == st_add_key);
    // Mix writes mid round; first and last rounds load in the key cycle
    assign load_state = (ctrl_st == st_mix) ||
                        (add_key && (round_cnt == 4'd0 || skip_mix));
    assign sub_start  = (ctrl_st == st_sub_bytes) && (byte_cnt == 4'd0);
    assign byte_idx   = byte_cnt;
    assign round      = round_cnt;
    assign done       = (ctrl_st == st_done);
    assign busy       = (ctrl_st != st_idle);

    // Key table has AES_KEYS entries
    assert property (@(posedge clk) disable iff (!resetn)
        round_cnt <= 4'(AES_ROUNDS));

endmodule

// ==== aes_key_rom.sv ====
//************************************************
// Pre-expanded AES-256 round key table, indexed by round.
//************************************************
`timescale 1ns/1ps

module aes_key_rom
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic [3:0] round,       // 0..AES_ROUNDS
    output aes_block_u round_key    // Valid one cycle after round
);

    logic [127:0] rom [AES_KEYS];   // One entry per round, core byte order

    // Key schedule for the fixed key, expanded offline
    initial
    begin
        $readmemh("aes_round_keys.mem", rom);
    end

    // Registered read, the controller leads by a cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            round_key <= '0;
        else
            round_key <= rom[round];
    end

endmodule

// ==== aes_mix_add.sv ====
//************************************************
// Round state register with MixColumns and AddRoundKey.
// Loads either the input block or the buffer output.
//************************************************
`timescale 1ns/1ps

module aes_mix_add
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       load_state,  // Take a new state word
    input  logic       add_key,     // XOR in round_key
    input  logic       skip_mix,    // Last round
    input  logic [3:0] round,
    input  aes_block_u inp_block,   // Captured plaintext
    input  aes_block_u shifted,     // From the ShiftRows buffer
    input  aes_block_u round_key,
    output aes_block_u state
);

    aes_block_u mixed;
    aes_block_u sel;
    aes_block_u next_state;

    always_comb
    begin
        for (int c = 0; c < 4; c++)
            mixed.col[c] = mix_column(shifted.col[c]);
    end

    always_comb
    begin
        // Round 0 starts from the plaintext
        if (round == 4'd0)
            sel = inp_block;
        else if (skip_mix)
            sel = shifted;
        else
            sel = mixed;

        next_state = load_state ? sel : state;

        // Load and key add may share a cycle
        if (add_key)
            for (int c = 0; c < 4; c++)
                next_state.col[c] = next_state.col[c] ^ round_key.col[c];
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= '0;
        else if (load_state || add_key)
            state <= next_state;
    end

endmodule

// ==== aes_pkg.sv ====
//************************************************
// Shared types, sizes and GF(2^8) helpers for the AES-256 encryption core.
// Imported by wildcard in each design module.
//************************************************

package aes_pkg;

    localparam int AES_ROUNDS  = 14;    // AES-256 round count
    localparam int AES_BYTES   = 16;    // Bytes in the state
    localparam int AES_KEYS    = 15;    // Round keys incl. initial key
    localparam int AES_LATENCY = 267;   // Start edge to done edge

    // One state word, seen as bytes or as columns
    // Byte k is FIPS state byte k, column c holds bytes 4c..4c+3
    typedef union packed {
        logic [AES_BYTES-1:0][7:0] b;   // Byte view, S-box and ShiftRows
        logic [3:0][31:0]          col; // Column view, MixColumns and key add
    } aes_block_u;

    typedef enum logic [2:0] {
        st_idle,
        st_add_key,
        st_sub_bytes,
        st_drain,       // Last S-box result still in flight
        st_mix,
        st_done
    } aes_ctrl_st_e;

    // Multiply by x modulo x^8+x^4+x^3+x+1
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add GF(2^8) product
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] acc;
        p   = a;
        acc = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ p;
            p = xtime(p);
        end
        return acc;
    endfunction

    // Inverse as a^254, then the affine map; zero maps to 63
    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] inv;
        sq  = a;
        inv = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);   // a^(2^i)
            inv = gf_mul(inv, sq);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    // Row 0 sits in the low byte of the column
    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] s0, s1, s2, s3;
        logic [7:0] r0, r1, r2, r3;
        s0 = col[7:0];
        s1 = col[15:8];
        s2 = col[23:16];
        s3 = col[31:24];
        r0 = xtime(s0) ^ xtime(s1) ^ s1 ^ s2 ^ s3;     // 2 3 1 1
        r1 = s0 ^ xtime(s1) ^ xtime(s2) ^ s2 ^ s3;     // 1 2 3 1
        r2 = s0 ^ s1 ^ xtime(s2) ^ xtime(s3) ^ s3;     // 1 1 2 3
        r3 = xtime(s0) ^ s0 ^ s1 ^ s2 ^ xtime(s3);     // 3 1 1 2
        return {r3, r2, r1, r0};
    endfunction

endpackage

// ==== aes_round_keys.mem ====
// AES-256 round keys 0..14 for key 000102..1f, one per line
// 128-bit hex, core byte order with FIPS byte 0 in the last two digits
0f0e0d0c0b0a09080706050403020100
1f1e1d1c1b1a19181716151413121110
9cc072a593ce7fa998c476a19fc273a5
deba4006c1a45d1adabe4402cda85116
6715fc03fbd58ea6681bf10ff0df87ae
8d51b87353ebf875924fa56f48f1e16d
8b59d56cec4c296f1799a7c97f8256c6
39cf0754b49ebf27e7754752753ae23d
2f1c87c1a44552ad48097bc25f90dc0b
0a820a64334d0d3087d3b21760a6f545
dfa761d2f0bbe61354feb4be1cf7cf7c
40e6afb34a64a5d77929a8e7fefa1af0
0a1c725ad5bb13882500f59b71fe4125
eacdf8cdaa2b577ee04ff2a999665a4e
36de686d3cc21a37e97909bfcc79fc24

// ==== aes_sbox_stream.sv ====
//************************************************
// Byte-serial SubBytes stage. Loads the state on sub_start and
// emits one substituted byte per cycle, byte 0 first.
//************************************************
`timescale 1ns/1ps

module aes_sbox_stream
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       sub_start,   // One cycle, state valid
    input  aes_block_u state,
    output logic [7:0] sub_byte,    // Registered S-box output
    output logic       sub_valid    // High for 16 result bytes
);

    logic [127:0] shreg;            // Bytes still to go, next in low byte
    logic [3:0]   left;             // Bytes left after the current one
    logic         feeding;
    logic [7:0]   feed_byte;

    assign feeding   = sub_start || (left != 4'd0);
    // Byte 0 bypasses the shift register
    assign feed_byte = sub_start ? state.b[0] : shreg[7:0];

    // Payload shift register
    always_ff @(posedge clk)
    begin
        if (sub_start)
            shreg <= {8'h00, state.b[AES_BYTES-1:1]};
        else if (left != 4'd0)
            shreg <= {8'h00, shreg[127:8]};    // Next byte down
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            left      <= 4'd0;
            sub_valid <= 1'b0;
            sub_byte  <= 8'h00;
        end
        else
        begin
            sub_valid <= feeding;               // Tracks the S-box register
            if (feeding)
                sub_byte <= sbox(feed_byte);
            if (sub_start)
                left <= 4'(AES_BYTES - 1);
            else if (left != 4'd0)
                left <= left - 4'd1;
        end
    end

endmodule

// ==== aes_shift_buffer.sv ====
//************************************************
// Collects the substituted bytes and reads them out through ShiftRows.
//************************************************
`timescale 1ns/1ps

module aes_shift_buffer
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       sub_valid,
    input  logic [3:0] byte_idx,    // Index of the byte entering the S-box
    input  logic [7:0] sub_byte,
    output aes_block_u shifted      // ShiftRows view of the stored bytes
);

    aes_block_u store;
    logic [3:0] idx_d;              // Index aligned with sub_byte

    // One cycle of delay, same as the S-box register
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            idx_d <= 4'd0;
        else
            idx_d <= byte_idx;
    end

    always_ff @(posedge clk)
    begin
        if (sub_valid)
            store.b[idx_d] <= sub_byte;
    end

    // Row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                shifted.b[r + 4*c] = store.b[r + 4*((c + r) % 4)];
    end

    // Stream starts at byte 0 and walks the block in order
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(sub_valid) |-> idx_d == 4'd0);
    assert property (@(posedge clk) disable iff (!resetn)
        sub_valid && $past(sub_valid) |-> idx_d == $past(idx_d) + 4'd1);

endmodule

// ==== tb_aes256_enc.sv ====
//************************************************
// Directed testbench for the AES-256 core on the FIPS-197 C.3 vector.
// Built and run by the Makefile, prints one pass or fail line.
//************************************************
`timescale 1ns/1ps

module tb_aes256_enc
    import aes_pkg::*;
();

    localparam int WAIT_LIMIT = AES_LATENCY + 20;   // Cycles before a wait gives up

    logic         clk;
    logic         resetn;
    logic [127:0] inp_aes;
    logic         ctrl_data_in;
    logic [127:0] out_aes;
    logic         ctrl_data_out;
    logic [15:0]  lfsr;             // Random source, one step per bit
    aes_block_u   plain_kat;        // FIPS vector in core byte order
    aes_block_u   cipher_kat;

    aes256_enc aes256_enc_inst (
        .clk(clk), .resetn(resetn), .inp_aes(inp_aes), .ctrl_data_in(ctrl_data_in),
        .out_aes(out_aes), .ctrl_data_out(ctrl_data_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_block(output aes_block_u blk);
        logic [127:0] v;
        for (int i = 0; i < 128; i++)
        begin
            v[i] = lfsr[0];         // Bit that falls out
            lfsr = lfsr_next(lfsr);
        end
        blk = v;
    endtask

    // FIPS text lists byte 0 first, the core keeps it in the low byte
    function automatic aes_block_u fips_to_core(input logic [127:0] f);
        aes_block_u blk;
        for (int k = 0; k < AES_BYTES; k++)
            blk.b[k] = f[127 - 8*k -: 8];
        return blk;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_block(input string test, input aes_block_u exp, input aes_block_u act);
        if (act !== exp)
        begin
            $display("mismatch %s expected %h actual %h", test, exp.b, act.b);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic compare_bit(input string test, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("mismatch %s expected %b actual %b", test, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic compare_count(input string test, input int exp, input int act);
        if (act != exp)
        begin
            $display("mismatch %s expected %0d actual %0d", test, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Caller sits on a falling edge or at time zero
    task automatic apply_reset(input string test);
        resetn       = 1'b0;
        ctrl_data_in = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            compare_bit(test, 1'b0, ctrl_data_out);     // Cleared while held
            compare_block(test, '0, out_aes);
        end
        resetn = 1'b1;
    endtask

    // One-cycle strobe, returns on the edge after capture
    task automatic start_block(input aes_block_u blk);
        @(negedge clk);
        inp_aes      = blk;
        ctrl_data_in = 1'b1;
        @(negedge clk);
        ctrl_data_in = 1'b0;
    endtask

    task automatic wait_done(input string test, output int cycles);
        cycles = 0;
        while (ctrl_data_out !== 1'b1)
        begin
            if (cycles >= WAIT_LIMIT)
                report_failure({test, ": no done strobe before the timeout"});
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_quiet(input string test, input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            if (ctrl_data_out !== 1'b0)
                report_failure({test, ": done strobe without a started block"});
        end
    endtask

    task automatic known_answer(input string test);
        int cycles;
        start_block(plain_kat);
        wait_done(test, cycles);
        compare_count(test, AES_LATENCY, cycles);   // Start edge to done edge
        compare_block(test, cipher_kat, out_aes);
    endtask

    task automatic idle_after_reset();
        compare_bit("idle_after_reset", 1'b0, ctrl_data_out);
        check_quiet("idle_after_reset", WAIT_LIMIT);
        compare_block("idle_after_reset", '0, out_aes);
    endtask

    // Junk strobes while busy must neither restart nor corrupt the block
    task automatic busy_strobes_ignored();
        aes_block_u junk;
        int         cycles;
        start_block(plain_kat);
        cycles = 0;
        while (ctrl_data_out !== 1'b1)
        begin
            if (cycles >= WAIT_LIMIT)
                report_failure("busy_strobes_ignored: no done strobe before the timeout");
            @(negedge clk);
            cycles++;
            if (cycles % 16 == 5 && cycles < 240)
            begin
                random_block(junk);
                inp_aes      = junk;
                ctrl_data_in = 1'b1;
            end
            else
                ctrl_data_in = 1'b0;
        end
        compare_count("busy_strobes_ignored", AES_LATENCY, cycles);
        compare_block("busy_strobes_ignored", cipher_kat, out_aes);
        check_quiet("busy_strobes_ignored", WAIT_LIMIT);    // Only one result
    endtask

    task automatic back_to_back();
        known_answer("back_to_back_first");
        known_answer("back_to_back_second");    // Counters start over
    endtask

    // Old result holds while the next block runs
    task automatic done_pulse_and_hold();
        aes_block_u other;
        int         cycles;
        start_block(plain_kat);
        wait_done("done_pulse_and_hold", cycles);
        inp_aes      = plain_kat;
        ctrl_data_in = 1'b1;        // Captured in the first idle cycle
        random_block(other);
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            ctrl_data_in = 1'b0;
            inp_aes      = other;   // After capture, must not matter
            compare_bit("done_pulse_and_hold", 1'b0, ctrl_data_out);
            compare_block("done_pulse_and_hold", cipher_kat, out_aes);
        end
        wait_done("done_pulse_and_hold_next", cycles);
        compare_count("done_pulse_and_hold_next", AES_LATENCY - 9, cycles);
        compare_block("done_pulse_and_hold_next", cipher_kat, out_aes);
    endtask

    task automatic reset_during_encrypt();
        start_block(plain_kat);
        repeat (100) @(negedge clk);    // Mid round 6
        apply_reset("reset_during_encrypt");
        check_quiet("reset_during_encrypt", WAIT_LIMIT);
        known_answer("reset_during_encrypt_rerun");
    endtask

    initial
    begin
        resetn       = 1'b0;
        ctrl_data_in = 1'b0;
        inp_aes      = '0;
        lfsr         = 16'd34;
        plain_kat    = fips_to_core(128'h00112233445566778899aabbccddeeff);
        cipher_kat   = fips_to_core(128'h8ea2b7ca516745bfeafc49904b496089);
        apply_reset("reset_state");
        idle_after_reset();
        known_answer("known_answer");
        busy_strobes_ignored();
        back_to_back();
        done_pulse_and_hold();
        reset_during_encrypt();
        $display("sim passed");
        $finish;
    end

endmodule
